/* source/cpu_pkg.sv */
package cpu_pkg;

    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW = $clog2(MEM_WORDS); // word index width
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // major opcodes of the kept subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    typedef enum logic [5:0] {
        ST_IDLE      = 6'b000000, // only right after reset
        ST_FETCH     = 6'b000001,
        ST_DECODE    = 6'b000010,
        ST_READ      = 6'b000100,
        ST_EXECUTE   = 6'b001000,
        ST_MEMORY    = 6'b010000,
        ST_WRITEBACK = 6'b100000
    } stage_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_SLT, ALU_SLTU, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_t;

    typedef enum logic [1:0] {WB_ALU, WB_IMM, WB_MEM, WB_PC4} wb_sel_t;
    typedef enum logic [1:0] {PC_PLUS4, PC_ALU, PC_IMM, PC_BRANCH} pc_sel_t;
    typedef enum logic [1:0] {SIZE_BYTE, SIZE_HALF, SIZE_WORD} mem_size_t; // matches funct3[1:0]

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
        logic       read_regs;
        logic       reg_write;
        alu_op_t    alu_op;
        logic       a_is_pc;
        logic       b_is_imm;
        logic       mem_access;
        logic       mem_write;
        mem_size_t  mem_size;
        logic       mem_unsigned;
        wb_sel_t    wb_sel;
        pc_sel_t    pc_sel;
    } ctrl_t;

    typedef struct packed {
        logic        en;
        logic        we;
        mem_size_t   size;
        logic        is_unsigned;
        logic [31:0] addr;  // byte address
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        rd_we;
        logic [31:0] value;
    } retire_t;

endpackage

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  logic [31:0]      a,
    input  logic [31:0]      b,
    output logic [31:0]      result
);
    import cpu_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign eq    = a == b;

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
            // compares and branch conditions land in bit 0
            ALU_SLT:  result = {31'd0, lt_s};
            ALU_SLTU: result = {31'd0, lt_u};
            ALU_EQ:   result = {31'd0, eq};
            ALU_NE:   result = {31'd0, !eq};
            ALU_LT:   result = {31'd0, lt_s};
            ALU_GE:   result = {31'd0, !lt_s};
            ALU_LTU:  result = {31'd0, lt_u};
            default:  result = {31'd0, !lt_u}; // geu
        endcase
    end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2,
    input  logic        we,
    input  logic [4:0]  rd,
    input  logic [31:0] wdata
);

    logic [31:0] regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

/* source/instruction_decode.sv */
`timescale 1ns/1ps

module instruction_decode (
    input  logic [31:0]    instr,
    output cpu_pkg::ctrl_t ctrl,
    output logic [31:0]    imm,
    output logic           illegal
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic alu_op_t branch_op(input logic [2:0] f3);
        case (f3)
            3'b000:  return ALU_EQ;
            3'b001:  return ALU_NE;
            3'b100:  return ALU_LT;
            3'b101:  return ALU_GE;
            3'b110:  return ALU_LTU;
            default: return ALU_GEU;
        endcase
    endfunction

    always_comb begin
        ctrl              = '0;
        ctrl.rs1          = instr[19:15];
        ctrl.rs2          = instr[24:20];
        ctrl.rd           = instr[11:7];
        ctrl.alu_op       = ALU_ADD;
        ctrl.wb_sel       = WB_ALU;
        ctrl.pc_sel       = PC_PLUS4;
        ctrl.mem_size     = mem_size_t'(funct3[1:0]);
        ctrl.mem_unsigned = funct3[2];
        imm               = {{20{instr[31]}}, instr[31:20]}; // I type unless overridden
        illegal           = 1'b0;
        case (opcode)
            OPC_OP: begin
                {ctrl.read_regs, ctrl.reg_write} = 2'b11;
                ctrl.alu_op = arith_op(funct3, funct7[5]);
                illegal = !(funct7 == 7'b0000000 ||
                            (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                {ctrl.read_regs, ctrl.reg_write, ctrl.b_is_imm} = 3'b111;
                ctrl.alu_op = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                if (funct3 == 3'b001) illegal = funct7 != 7'b0000000;
                if (funct3 == 3'b101) illegal = funct7 != 7'b0000000 && funct7 != 7'b0100000;
            end
            OPC_LUI, OPC_AUIPC: begin
                {ctrl.reg_write, ctrl.a_is_pc, ctrl.b_is_imm} = 3'b111;
                imm = {instr[31:12], 12'b0};
                if (opcode == OPC_LUI) ctrl.wb_sel = WB_IMM;
            end
            OPC_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel = WB_PC4;
                ctrl.pc_sel = PC_IMM;
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_JALR: begin
                {ctrl.read_regs, ctrl.reg_write, ctrl.b_is_imm} = 3'b111;
                ctrl.wb_sel = WB_PC4;
                ctrl.pc_sel = PC_ALU;
                illegal = funct3 != 3'b000;
            end
            OPC_BRANCH: begin
                ctrl.read_regs = 1'b1;
                ctrl.alu_op = branch_op(funct3);
                ctrl.pc_sel = PC_BRANCH;
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                illegal = funct3[2:1] == 2'b01;
            end
            OPC_LOAD: begin
                {ctrl.read_regs, ctrl.reg_write, ctrl.b_is_imm, ctrl.mem_access} = 4'b1111;
                ctrl.wb_sel = WB_MEM;
                illegal = funct3[1:0] == 2'b11 || funct3 == 3'b110; // no ld, lwu
            end
            OPC_STORE: begin
                {ctrl.read_regs, ctrl.b_is_imm, ctrl.mem_access, ctrl.mem_write} = 4'b1111;
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                illegal = funct3[2] || funct3[1:0] == 2'b11;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

/* source/memory.sv */
`timescale 1ns/1ps

module memory (
    input  logic                        clk,
    input  logic                        reset,
    input  cpu_pkg::mem_req_t           req,
    output logic [31:0]                 rdata,
    output logic                        fault,
    input  logic                        prog_we,
    input  logic [cpu_pkg::MEM_AW-1:0]  prog_addr,
    input  logic [31:0]                 prog_data
);
    import cpu_pkg::*;

    logic [31:0]       mem [MEM_WORDS];
    logic [MEM_AW-1:0] index;
    logic              misaligned;
    logic [31:0]       word_q;
    logic [1:0]        offset_q;
    mem_size_t         size_q;
    logic              unsigned_q;
    logic [31:0]       lane;

    assign index = req.addr[MEM_AW+1:2];

    always_comb begin
        case (req.size)
            SIZE_HALF: misaligned = req.addr[0];
            SIZE_WORD: misaligned = req.addr[1:0] != 2'b00;
            default:   misaligned = 1'b0;
        endcase
    end

    assign fault = req.en && (misaligned || req.addr[31:MEM_AW+2] != '0);

    always_ff @(posedge clk) begin
        if (reset && prog_we) begin
            mem[prog_addr] <= prog_data;
        end else if (req.en && req.we && !fault) begin
            case (req.size)
                SIZE_BYTE: mem[index][{req.addr[1:0], 3'b000} +: 8] <= req.wdata[7:0];
                SIZE_HALF: mem[index][{req.addr[1], 4'b0000} +: 16] <= req.wdata[15:0];
                default:   mem[index] <= req.wdata;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req.en && !fault) begin
            word_q     <= mem[index];
            offset_q   <= req.addr[1:0]; // lane info for the extension next cycle
            size_q     <= req.size;
            unsigned_q <= req.is_unsigned;
        end
    end

    always_comb begin
        lane = word_q >> {offset_q, 3'b000};
        case (size_q)
            SIZE_BYTE: rdata = {{24{!unsigned_q && lane[7]}}, lane[7:0]};
            SIZE_HALF: rdata = {{16{!unsigned_q && lane[15]}}, lane[15:0]};
            default:   rdata = word_q;
        endcase
    end

    prog_in_reset: assert property (@(posedge clk) prog_we |-> reset);

endmodule

/* source/core.sv */
`timescale 1ns/1ps

module core (
    input  logic               clk,
    input  logic               reset,
    output cpu_pkg::mem_req_t  mem_req,
    input  logic [31:0]        mem_rdata,
    input  logic               mem_fault,
    output logic               retire_valid,
    output cpu_pkg::retire_t   retire,
    output logic               fault
);
    import cpu_pkg::*;

    stage_t      stage_q;
    logic [31:0] pc_q;
    logic [31:0] instr_q;
    logic [31:0] rs1_q;
    logic [31:0] rs2_q;
    logic [31:0] alu_q;
    logic        fault_q;
    ctrl_t       ctrl;
    logic [31:0] imm;
    logic        illegal;
    logic [31:0] instr_word;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] alu_y;
    logic [31:0] pc_plus4;
    logic [31:0] pc_imm;
    logic [31:0] next_pc;
    logic [31:0] wb_value;
    logic        target_fault;
    logic        fault_set;

    // fetched word is only on the memory bus during decode
    assign instr_word = (stage_q == ST_DECODE) ? mem_rdata : instr_q;

    instruction_decode decode_module (.instr(instr_word), .ctrl(ctrl), .imm(imm), .illegal(illegal));

    register_file rf_module (
        .clk(clk), .reset(reset), .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rdata1(rdata1), .rdata2(rdata2),
        .we(retire_valid && ctrl.reg_write), .rd(ctrl.rd), .wdata(wb_value)
    );

    alu alu_module (
        .op(ctrl.alu_op),
        .a(ctrl.a_is_pc ? pc_q : rs1_q),
        .b(ctrl.b_is_imm ? imm : rs2_q),
        .result(alu_y)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_q <= ST_IDLE;
        end else if (!fault_q && !fault_set) begin
            case (stage_q)
                ST_IDLE:      stage_q <= ST_FETCH;
                ST_FETCH:     stage_q <= ST_DECODE;
                ST_DECODE:    stage_q <= ctrl.read_regs ? ST_READ : ST_EXECUTE;
                ST_READ:      stage_q <= ST_EXECUTE;
                ST_EXECUTE:   stage_q <= ctrl.mem_access ? ST_MEMORY : ST_WRITEBACK;
                ST_MEMORY:    stage_q <= ST_WRITEBACK;
                default:      stage_q <= ST_FETCH; // write back
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (stage_q == ST_DECODE) instr_q <= mem_rdata;
        if (stage_q == ST_READ) begin
            rs1_q <= rdata1;
            rs2_q <= rdata2;
        end
        if (stage_q == ST_EXECUTE) alu_q <= alu_y;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q    <= RESET_PC;
            fault_q <= 1'b0;
        end else begin
            if (retire_valid) pc_q <= next_pc;
            if (fault_set) fault_q <= 1'b1; // sticky until reset
        end
    end

    always_comb begin
        mem_req             = '0;
        mem_req.en          = !fault_q && (stage_q == ST_FETCH || stage_q == ST_MEMORY);
        mem_req.size        = SIZE_WORD;
        mem_req.addr        = pc_q;
        if (stage_q == ST_MEMORY) begin
            mem_req.we          = ctrl.mem_write;
            mem_req.size        = ctrl.mem_size;
            mem_req.is_unsigned = ctrl.mem_unsigned;
            mem_req.addr        = alu_q;
            mem_req.wdata       = rs2_q;
        end
    end

    assign pc_plus4 = pc_q + 32'd4;
    assign pc_imm   = pc_q + imm;

    always_comb begin
        case (ctrl.pc_sel)
            PC_ALU:    next_pc = alu_q; // jalr target taken as is, odd bits fault below
            PC_IMM:    next_pc = pc_imm;
            PC_BRANCH: next_pc = alu_q[0] ? pc_imm : pc_plus4;
            default:   next_pc = pc_plus4;
        endcase
        case (ctrl.wb_sel)
            WB_IMM:  wb_value = imm;
            WB_MEM:  wb_value = mem_rdata;
            WB_PC4:  wb_value = pc_plus4;
            default: wb_value = alu_q;
        endcase
    end

    assign target_fault = (stage_q == ST_WRITEBACK) && (next_pc[1:0] != 2'b00);
    assign fault_set    = !fault_q &&
                          (((stage_q == ST_DECODE) && illegal) || mem_fault || target_fault);

    assign retire_valid = (stage_q == ST_WRITEBACK) && !fault_q && !target_fault;
    assign retire       = '{pc: pc_q, rd: ctrl.rd, rd_we: ctrl.reg_write, value: wb_value};
    assign fault        = fault_q;

    // bad targets fault in write back before they reach fetch
    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        (stage_q == ST_FETCH) |-> (pc_q[1:0] == 2'b00));
    // memory only flags requests that the core actually makes
    fault_on_request: assert property (@(posedge clk) disable iff (reset)
        mem_fault |-> mem_req.en);

endmodule

/* source/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        prog_we,
    input  logic [cpu_pkg::MEM_AW-1:0]  prog_addr,  // word index
    input  logic [31:0]                 prog_data,
    output logic                        retire_valid,
    output cpu_pkg::retire_t            retire,
    output logic                        fault
);
    import cpu_pkg::*;

    mem_req_t    mem_req;
    logic [31:0] mem_rdata;
    logic        mem_fault;

    core core_module (
        .clk(clk), .reset(reset),
        .mem_req(mem_req), .mem_rdata(mem_rdata), .mem_fault(mem_fault),
        .retire_valid(retire_valid), .retire(retire), .fault(fault)
    );

    // shared instruction and data memory
    memory mem_module (
        .clk(clk), .reset(reset),
        .req(mem_req), .rdata(mem_rdata), .fault(mem_fault),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data)
    );

endmodule

/* sim/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
    parameter int HALF_PERIOD  = 4,  // 8 ns clock
    parameter int RESET_CYCLES = 16
) (
    input  logic hold,   // keeps reset high while a program is loaded
    output logic clk,
    output logic reset
);

    int count = 0;

    initial begin
        clk   = 1'b0;
        reset = 1'b1;
    end

    always #HALF_PERIOD clk = ~clk;

    always @(posedge clk) begin
        if (hold) count <= 0;
        else if (count < RESET_CYCLES) count <= count + 1;
    end

    always @(negedge clk) reset <= count < RESET_CYCLES; // released 16 cycles after hold drops

endmodule

/* sim/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
    import cpu_pkg::*;

    logic              clk;
    logic              reset;
    logic              hold;
    logic              prog_we;
    logic [MEM_AW-1:0] prog_addr;
    logic [31:0]       prog_data;
    logic              retire_valid;
    retire_t           retire;
    logic              fault;

    logic [31:0] prog [$];
    logic [31:0] ref_mem [MEM_WORDS];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    string       test_name;
    logic        checking = 1'b0;
    logic        fault_seen;
    int          retired;
    int          errors = 0;
    int          pass_count = 0;
    int          fail_count = 0;

    clock_gen clocks (.hold(hold), .clk(clk), .reset(reset));

    cpu_top DUT (
        .clk(clk), .reset(reset),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .retire_valid(retire_valid), .retire(retire), .fault(fault)
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
            input logic [11:0] imm);
        return i_type(imm, rs1, 3'd0, rd, OPC_OP_IMM);
    endfunction

    function automatic logic [31:0] fill_word(input int index);
        return 32'(index) * 32'h9e37_79b9 ^ 32'h5ca1_ab1e; // odd multiplier, all address bits count
    endfunction

    function automatic logic [31:0] random_alu_instr();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        rd  = 5'($urandom_range(8)); // x0 included on purpose
        rs1 = 5'($urandom_range(8));
        rs2 = 5'($urandom_range(8));
        f3  = 3'($urandom);
        imm = 12'($urandom);
        alt = (f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1) == 1;
        case ($urandom_range(4))
            0, 1: return r_type(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OPC_OP);
            2: begin
                if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'b0, imm[4:0]}; // shift forms
                return i_type(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            3: return u_type(20'($urandom), rd, OPC_LUI);
            default: return u_type(20'($urandom), rd, OPC_AUIPC);
        endcase
    endfunction

    // reference ISA behavior
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
            input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic bad_access(input logic [31:0] addr, input logic [2:0] f3);
        return (f3[1:0] == 2'd1 && addr[0]) || (f3[1:0] == 2'd2 && addr[1:0] != 2'd0) ||
               addr >= 32'(MEM_WORDS * 4);
    endfunction

    // executes the instruction at ref_pc, returns what should retire
    function automatic retire_t model_step(output logic faulted);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] lane;
        logic [31:0] val;
        logic [31:0] npc;
        logic [2:0]  f3;
        logic        we;
        retire_t     r;
        ins     = ref_mem[ref_pc[MEM_AW+1:2]];
        f3      = ins[14:12];
        a       = ref_regs[ins[19:15]];
        b       = ref_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        addr    = a + ((ins[6:0] == OPC_STORE) ? {{20{ins[31]}}, ins[31:25], ins[11:7]} : imm_i);
        val     = ref_pc + 32'd4; // link value for jumps
        npc     = ref_pc + 32'd4;
        we      = 1'b1;
        faulted = 1'b0;
        case (ins[6:0])
            OPC_OP:     val = alu_ref(f3, ins[30], a, b);
            OPC_OP_IMM: val = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
            OPC_LUI:    val = {ins[31:12], 12'h000};
            OPC_AUIPC:  val = ref_pc + {ins[31:12], 12'h000};
            OPC_JAL:    npc = ref_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            OPC_JALR:   npc = addr; // no bit clearing, odd targets fault
            OPC_BRANCH: begin
                we = 1'b0;
                if (branch_taken(f3, a, b))
                    npc = ref_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            OPC_LOAD: begin
                faulted = bad_access(addr, f3);
                lane = ref_mem[addr[MEM_AW+1:2]] >> {addr[1:0], 3'b000};
                case (f3)
                    3'd0: val = {{24{lane[7]}}, lane[7:0]};
                    3'd1: val = {{16{lane[15]}}, lane[15:0]};
                    3'd4: val = {24'd0, lane[7:0]};
                    3'd5: val = {16'd0, lane[15:0]};
                    default: val = lane;
                endcase
            end
            OPC_STORE: begin
                we = 1'b0;
                faulted = bad_access(addr, f3);
                if (!faulted) begin
                    lane = ref_mem[addr[MEM_AW+1:2]];
                    case (f3[1:0])
                        2'd0: lane[{addr[1:0], 3'b000} +: 8] = b[7:0];
                        2'd1: lane[{addr[1], 4'b0000} +: 16] = b[15:0];
                        default: lane = b;
                    endcase
                    ref_mem[addr[MEM_AW+1:2]] = lane;
                end
            end
            default: faulted = 1'b1; // not an instruction of the subset
        endcase
        if (npc[1:0] != 2'b00) faulted = 1'b1;
        r.pc    = ref_pc;
        r.rd    = we ? ins[11:7] : 5'd0;
        r.rd_we = we;
        r.value = we ? val : 32'd0;
        if (!faulted) begin
            if (we && ins[11:7] != 5'd0) ref_regs[ins[11:7]] = val;
            ref_pc = npc;
        end
        return r;
    endfunction

    // rd and value mean nothing when no register is written
    function automatic retire_t masked(input retire_t r);
        retire_t m;
        m = r;
        if (!m.rd_we) begin
            m.rd    = '0;
            m.value = '0;
        end
        return m;
    endfunction

    task automatic compare(input string name, input logic [69:0] expected,
            input logic [69:0] actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        retire_t expected;
        logic    model_fault;
        if (checking && !reset) begin
            if (retire_valid) begin
                expected = model_step(model_fault);
                if (model_fault) begin
                    $display("Error in %s: pc %h retired but should have faulted",
                             test_name, expected.pc);
                    errors++;
                end else begin
                    compare(test_name, expected, masked(retire));
                end
                retired <= retired + 1;
            end else if (fault && !fault_seen) begin
                fault_seen = 1'b1;
                expected = model_step(model_fault);
                if (!model_fault) begin
                    $display("Error in %s: fault raised at pc %h, which should execute normally",
                             test_name, expected.pc);
                    errors++;
                end
            end
        end
    end

    task automatic run_test(input string name, input int min_retires, input logic expect_fault);
        int start_errors;
        int cycles;
        test_name    = name;
        start_errors = errors;
        hold         = 1'b1;
        cycles       = 0;
        while (!reset && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (!reset) begin
            $display("Timeout in %s: reset did not rise", name);
            errors++;
        end
        @(negedge clk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            compare({name, " in reset"}, 70'd0, {retire_valid, fault});
            ref_mem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
            prog_we    = 1'b1;
            prog_addr  = MEM_AW'(i);
            prog_data  = ref_mem[i];
            @(negedge clk);
        end
        prog_we = 1'b0;
        hold    = 1'b0;
        for (int i = 0; i < 32; i++) ref_regs[i] = 32'd0;
        ref_pc     = RESET_PC;
        retired    = 0;
        fault_seen = 1'b0;
        checking  <= 1'b1;
        cycles     = 0;
        while (reset && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (reset) begin
            $display("Timeout in %s: reset was never released", name);
            errors++;
        end
        compare({name, " after reset"}, 70'd0, {retire_valid, fault}); // first cycle out of reset
        cycles = 0;
        while (retired < min_retires && cycles < 8 * min_retires + 100) begin
            @(negedge clk);
            cycles++;
        end
        if (retired < min_retires) begin
            $display("Timeout in %s: only %0d of %0d instructions retired",
                     name, retired, min_retires);
            errors++;
        end
        if (expect_fault) begin
            cycles = 0;
            while (!fault && cycles < 100) begin
                @(negedge clk);
                cycles++;
            end
            if (!fault) begin
                $display("Timeout in %s: the fault output never went high", name);
                errors++;
            end
            for (int i = 0; i < 50; i++) @(negedge clk); // window where nothing may retire
            compare({name, " retire count"}, 70'(min_retires), 70'(retired));
        end else begin
            compare({name, " fault"}, 70'd0, {69'd0, fault});
        end
        checking <= 1'b0;
        @(negedge clk);
        if (errors == start_errors) pass_count++;
        else fail_count++;
        $display("%s: %s, %0d instructions retired", name,
                 (errors == start_errors) ? "ok" : "failed", retired);
    endtask

    task automatic build_alu_program();
        prog.delete();
        for (int r = 1; r <= 8; r++) begin
            prog.push_back(u_type(20'($urandom), 5'(r), OPC_LUI));
            prog.push_back(addi(5'(r), 5'(r), 12'($urandom)));
        end
        for (int k = 0; k < 30; k++) prog.push_back(random_alu_instr());
        prog.push_back(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd10, OPC_OP)); // x0 still reads zero
        prog.push_back(j_type(21'd0, 5'd0));
    endtask

    task automatic build_memory_program();
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'h600));   // data base, word 384
        for (int r = 2; r <= 3; r++) begin
            prog.push_back(u_type(20'($urandom), 5'(r), OPC_LUI));
            prog.push_back(addi(5'(r), 5'(r), 12'($urandom)));
        end
        prog.push_back(s_type(12'd0, 5'd2, 5'd1, 3'd2));
        prog.push_back(s_type(12'd4, 5'd3, 5'd1, 3'd2));
        prog.push_back(s_type(12'd8, 5'd3, 5'd1, 3'd1));
        prog.push_back(s_type(12'd10, 5'd2, 5'd1, 3'd1));
        for (int i = 0; i < 4; i++) begin
            prog.push_back(s_type(12'(12 + i), 5'(2 + i % 2), 5'd1, 3'd0));
        end
        for (int off = 0; off < 20; off++) begin  // bytes 16..19 still hold fill data
            prog.push_back(i_type(12'(off), 5'd1, 3'd0, 5'(4 + off % 8), OPC_LOAD));
            prog.push_back(i_type(12'(off), 5'd1, 3'd4, 5'(4 + off % 8), OPC_LOAD));
        end
        for (int off = 0; off < 20; off += 2) begin
            prog.push_back(i_type(12'(off), 5'd1, 3'd1, 5'd12, OPC_LOAD));
            prog.push_back(i_type(12'(off), 5'd1, 3'd5, 5'd13, OPC_LOAD));
        end
        for (int off = 0; off < 20; off += 4) begin
            prog.push_back(i_type(12'(off), 5'd1, 3'd2, 5'd14, OPC_LOAD));
        end
        prog.push_back(j_type(21'd0, 5'd0));
    endtask

    task automatic build_branch_program();
        prog.delete();
        prog.push_back(u_type({1'b1, 19'($urandom)}, 5'd1, OPC_LUI)); // negative
        prog.push_back(addi(5'd1, 5'd1, 12'($urandom)));
        prog.push_back(u_type({1'b0, 19'($urandom)}, 5'd2, OPC_LUI)); // positive
        prog.push_back(addi(5'd2, 5'd2, 12'($urandom)));
        for (int f3 = 0; f3 < 8; f3++) begin
            if (f3 == 2 || f3 == 3) continue;
            for (int p = 0; p < 3; p++) begin
                prog.push_back(b_type(13'd8, (p == 0) ? 5'd2 : 5'd1, (p == 1) ? 5'd2 : 5'd1,
                                      3'(f3)));
                prog.push_back(addi(5'd5, 5'd5, 12'd1)); // skipped when taken
            end
        end
        prog.push_back(addi(5'd10, 5'd0, 12'd3));
        prog.push_back(addi(5'd10, 5'd10, 12'hfff));
        prog.push_back(b_type(13'h1ffc, 5'd0, 5'd10, 3'd1)); // backward loop, three passes
        prog.push_back(u_type(20'd0, 5'd7, OPC_AUIPC));
        prog.push_back(i_type(12'd12, 5'd7, 3'd0, 5'd8, OPC_JALR));
        prog.push_back(addi(5'd5, 5'd5, 12'd1));
        prog.push_back(j_type(21'd8, 5'd6));
        prog.push_back(addi(5'd5, 5'd5, 12'd1));
        prog.push_back(r_type(7'h00, 5'd0, 5'd5, 3'd0, 5'd9, OPC_OP));
        prog.push_back(j_type(21'd0, 5'd0));
    endtask

    initial begin
        void'($urandom(32'h1ba24342));
        hold       = 1'b1;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_data  = '0;
        build_alu_program();
        run_test("alu_random", 50, 1'b0);
        build_memory_program();
        run_test("load_store", 80, 1'b0);
        build_branch_program();
        run_test("control_flow", 55, 1'b0);
        prog = '{addi(5'd1, 5'd0, 12'd5), addi(5'd2, 5'd1, 12'd1), 32'h0000_0000};
        run_test("fault_illegal", 2, 1'b1);
        prog = '{addi(5'd1, 5'd0, 12'h602), i_type(12'd0, 5'd1, 3'd2, 5'd2, OPC_LOAD)};
        run_test("fault_misaligned_load", 1, 1'b1);
        prog = '{u_type(20'd0, 5'd1, OPC_AUIPC), i_type(12'd9, 5'd1, 3'd0, 5'd2, OPC_JALR)};
        run_test("fault_odd_jalr", 1, 1'b1);
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* src.f */
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/instruction_decode.sv
source/memory.sv
source/core.sv
source/cpu_top.sv
sim/clock_gen.sv
sim/tb_cpu.sv
